//--- logic/spi_tx_cfg.svh
/*
 * sizing macros for the SPI transmitter
 * frame width, bit counter width and FIFO geometry
 */
`ifndef SPI_TX_CFG_SVH
`define SPI_TX_CFG_SVH

// number of bits sent per frame, one FIFO word per frame
`define SPI_DATA_WIDTH 8

// bit counter must be able to hold the full frame length
`define SPI_BIT_COUNT_WIDTH 4

// number of words the FIFO can hold
`define FIFO_DEPTH 8

// pointer width, enough to index FIFO_DEPTH entries
`define FIFO_ADDR_WIDTH 3

`endif

//--- logic/fifo_pkg.sv
/*
 * FIFO types: data word and full/empty status
 */
`include "spi_tx_cfg.svh"

package fifo_pkg;

    // one data word, which is also one SPI frame
    typedef logic [`SPI_DATA_WIDTH-1:0] word_t;

    // status flags seen by the writer and by the serializer
    // full drives the write back-pressure, empty starts a new frame
    typedef struct packed {
        logic full;
        logic empty;
    } fifo_status_t;

endpackage

//--- logic/spi_pkg.sv
/*
 * SPI serializer types: controller state encoding and pin bundle
 */
package spi_pkg;

    // frame controller states
    // IDLE waits for data, LOAD pops one word from the FIFO,
    // SHIFT drives the bits out, COMPLETE raises done for one cycle
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOAD     = 2'd1,
        SHIFT    = 2'd2,
        COMPLETE = 2'd3
    } spi_state_t;

    // serial pins driven towards the slave
    // transmit only, so there is no miso and no chip select
    typedef struct packed {
        logic sclk;
        logic mosi;
    } spi_pins_t;

endpackage

//--- logic/sync_fifo.sv
/*
 * single-clock FIFO with occupancy count and full/empty flags
 * read data is shown combinationally from the head entry
 */
`timescale 1ns/1ns
`include "spi_tx_cfg.svh"

module sync_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_en,
    input  fifo_pkg::word_t        wr_data,
    input  logic                   rd_en,
    output fifo_pkg::word_t        rd_data,
    output fifo_pkg::fifo_status_t status
);

    // storage array, indexed by the two circular pointers
    fifo_pkg::word_t mem [`FIFO_DEPTH];

    logic [`FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [`FIFO_ADDR_WIDTH-1:0] rd_ptr;

    // one extra bit so that a completely full FIFO can be counted
    logic [`FIFO_ADDR_WIDTH:0] count;

    logic do_write;
    logic do_read;

    // a write into a full FIFO or a read from an empty one is dropped
    assign do_write = wr_en && !status.full;
    assign do_read  = rd_en && !status.empty;

    // flags come straight from the count, so empty is high out of reset
    assign status.full  = (count == (`FIFO_ADDR_WIDTH+1)'(`FIFO_DEPTH));
    assign status.empty = (count == '0);

    // oldest word is always visible to the reader
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap at the last entry, which also covers depths that are
    // not a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                if (wr_ptr == `FIFO_ADDR_WIDTH'(`FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_read) begin
                if (rd_ptr == `FIFO_ADDR_WIDTH'(`FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    // a simultaneous read and write leaves the occupancy unchanged
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/spi_sclk_gen.sv
/*
 * SPI clock divider with one-cycle edge strobes
 */
`timescale 1ns/1ns

module spi_sclk_gen (
    input  logic clk,
    input  logic rst,
    input  logic sclk_enable,
    output logic sclk,
    output logic fall_pulse,
    output logic rise_pulse
);

    // divide-by-two phase, free running even when sclk is idle
    logic clk_div;

    // sclk toggles only on the high phase of clk_div, which gives
    // one sclk period every 4 clk cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_div <= 1'b0;
            sclk    <= 1'b0;
        end else begin
            clk_div <= ~clk_div;
            if (!sclk_enable) begin
                // park the clock low between frames
                sclk <= 1'b0;
            end else if (clk_div) begin
                sclk <= ~sclk;
            end
        end
    end

    // strobes are high in the clk cycle at whose end sclk changes,
    // so the user updates its registers together with the sclk edge
    assign rise_pulse = sclk_enable && clk_div && !sclk;
    assign fall_pulse = sclk_enable && clk_div && sclk;

endmodule

//--- logic/spi_serializer.sv
/*
 * SPI frame controller with shift register and bit counter
 * pops one FIFO word per frame and sends it MSB first on mosi
 */
`timescale 1ns/1ns
`include "spi_tx_cfg.svh"

module spi_serializer (
    input  logic                   clk,
    input  logic                   rst,
    input  fifo_pkg::fifo_status_t status,
    input  fifo_pkg::word_t        rd_data,
    output logic                   rd_en,
    output spi_pkg::spi_pins_t     pins,
    output logic                   done
);

    spi_pkg::spi_state_t state;
    spi_pkg::spi_state_t next_state;

    fifo_pkg::word_t                 shift_reg;
    logic [`SPI_BIT_COUNT_WIDTH-1:0] bit_cnt;

    // set once the current mosi bit has been seen by a rising sclk edge
    logic bit_clocked;
    logic shift_now;

    logic sclk_enable;
    logic sclk;
    logic fall_pulse;
    logic rise_pulse;

    spi_sclk_gen sclk_gen_i (
        .clk         (clk),
        .rst         (rst),
        .sclk_enable (sclk_enable),
        .sclk        (sclk),
        .fall_pulse  (fall_pulse),
        .rise_pulse  (rise_pulse)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= spi_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // LOAD and COMPLETE always last exactly one cycle
    always_comb begin
        next_state = state;
        case (state)
            spi_pkg::IDLE: begin
                if (!status.empty) begin
                    next_state = spi_pkg::LOAD;
                end
            end
            spi_pkg::LOAD: next_state = spi_pkg::SHIFT;
            spi_pkg::SHIFT: begin
                if (bit_cnt == '0) begin
                    next_state = spi_pkg::COMPLETE;
                end
            end
            default: next_state = spi_pkg::IDLE;
        endcase
    end

    // move to the next bit on a falling sclk edge, but only after the
    // slave has had a rising edge to sample the current one
    assign shift_now = (state == spi_pkg::SHIFT) && fall_pulse && bit_clocked;

    // payload register, its contents only matter while in SHIFT
    always_ff @(posedge clk) begin
        if (state == spi_pkg::LOAD) begin
            shift_reg <= rd_data;
        end else if (shift_now) begin
            shift_reg <= shift_reg << 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt     <= '0;
            bit_clocked <= 1'b0;
        end else if (state == spi_pkg::LOAD) begin
            bit_cnt     <= `SPI_BIT_COUNT_WIDTH'(`SPI_DATA_WIDTH);
            bit_clocked <= 1'b0;
        end else if (shift_now) begin
            bit_cnt     <= bit_cnt - 1'b1;
            bit_clocked <= 1'b0;
        end else if (rise_pulse) begin
            bit_clocked <= 1'b1;
        end
    end

    // the FIFO head is popped in the same cycle it is copied in
    assign rd_en       = (state == spi_pkg::LOAD);
    assign sclk_enable = (state == spi_pkg::SHIFT);
    assign done        = (state == spi_pkg::COMPLETE);

    assign pins.sclk = sclk;
    // mosi idles low outside SHIFT
    assign pins.mosi = (state == spi_pkg::SHIFT) ? shift_reg[`SPI_DATA_WIDTH-1] : 1'b0;

endmodule

//--- logic/spi_tx_top.sv
/*
 * SPI transmitter top level: write FIFO feeding the serializer
 */
`timescale 1ns/1ns

module spi_tx_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wr_valid,
    input  fifo_pkg::word_t        wr_data,
    output logic                   wr_ready,
    output fifo_pkg::fifo_status_t status,
    output spi_pkg::spi_pins_t     pins,
    output logic                   done
);

    logic            wr_en;
    logic            rd_en;
    fifo_pkg::word_t rd_data;

    // writer is held off while the FIFO is full
    assign wr_ready = !status.full;
    assign wr_en    = wr_valid && wr_ready;

    sync_fifo fifo_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .status  (status)
    );

    // the serializer sees the same status flags that are exported
    spi_serializer serializer_i (
        .clk     (clk),
        .rst     (rst),
        .status  (status),
        .rd_data (rd_data),
        .rd_en   (rd_en),
        .pins    (pins),
        .done    (done)
    );

endmodule

//--- verification/spi_tx_assertions.sv
/*
 * concurrent protocol assertions for the SPI serializer FSM
 * and the bind that attaches them to every serializer instance
 */
`timescale 1ns/1ns

module spi_tx_assertions (
    input logic                clk,
    input logic                rst,
    input spi_pkg::spi_state_t state,
    input logic                rd_en,
    input logic                done,
    input logic                sclk_enable,
    input logic                sclk
);

    // count of failed properties, polled by the testbench every cycle
    int unsigned fail_count = 0;

    // LOAD is a single cycle and always hands over to SHIFT
    load_then_shift: assert property (@(posedge clk) disable iff (rst)
        state == spi_pkg::LOAD |=> state == spi_pkg::SHIFT)
        else begin
            fail_count++;
            $error("LOAD was not followed by SHIFT");
        end

    // COMPLETE returns to IDLE after one cycle
    complete_then_idle: assert property (@(posedge clk) disable iff (rst)
        state == spi_pkg::COMPLETE |=> state == spi_pkg::IDLE)
        else begin
            fail_count++;
            $error("COMPLETE was not followed by IDLE");
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    // exactly one FIFO pop per frame
    rd_en_single_cycle: assert property (@(posedge clk) disable iff (rst)
        rd_en |=> !rd_en)
        else begin
            fail_count++;
            $error("rd_en stayed high for more than one cycle");
        end

    rd_en_only_in_load: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> state == spi_pkg::LOAD)
        else begin
            fail_count++;
            $error("rd_en was high outside LOAD");
        end

    // sclk must already be parked low whenever the divider is off
    sclk_quiet_when_disabled: assert property (@(posedge clk) disable iff (rst)
        !sclk_enable |=> $stable(sclk))
        else begin
            fail_count++;
            $error("sclk changed while sclk_enable was low");
        end

endmodule

bind spi_serializer spi_tx_assertions spi_tx_assertions_i (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .rd_en       (rd_en),
    .done        (done),
    .sclk_enable (sclk_enable),
    .sclk        (sclk)
);

//--- verification/spi_tx_tb.sv
/*
 * testbench for the SPI transmitter: clock, reset, write stimulus,
 * mosi receiver model and checks through immediate assertions
 */
`timescale 1ns/1ns
`include "spi_tx_cfg.svh"

module spi_tx_tb;

    // longest wait for a single handshake or frame, in clk cycles
    localparam int WAIT_LIMIT = 100;

    logic                   clk;
    logic                   rst;
    logic                   wr_valid;
    fifo_pkg::word_t        wr_data;
    logic                   wr_ready;
    fifo_pkg::fifo_status_t status;
    spi_pkg::spi_pins_t     pins;
    logic                   done;

    integer          seed;
    fifo_pkg::word_t expected_q[$];
    fifo_pkg::word_t rx_word;
    int              rx_bits;
    int              done_count;
    logic            sclk_prev;
    logic            saw_full;

    spi_tx_top spi_tx_top_i (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_data  (wr_data),
        .wr_ready (wr_ready),
        .status   (status),
        .pins     (pins),
        .done     (done)
    );

    always #2 clk = ~clk;

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        report_failure();
    endtask

    // receiver model, runs mid-cycle where sclk, mosi and done are settled
    // a rising sclk seen here is the slave's sampling point for mosi
    always @(negedge clk) begin
        if (!rst) begin
            if (pins.sclk && !sclk_prev) begin
                rx_word = {rx_word[`SPI_DATA_WIDTH-2:0], pins.mosi};
                rx_bits++;
            end
            if (done) begin
                assert (expected_q.size() > 0) else begin
                    $display("done pulsed while no written word was outstanding");
                    report_failure();
                end
                assert (rx_bits == `SPI_DATA_WIDTH)
                    else show_mismatch("rx_bits", rx_bits, `SPI_DATA_WIDTH);
                assert (rx_word == expected_q[0])
                    else show_mismatch("rx_word", rx_word, expected_q[0]);
                void'(expected_q.pop_front());
                rx_bits = 0;
                done_count++;
            end
            if (status.full) begin
                saw_full = 1'b1;
            end
            assert (wr_ready == !status.full)
                else show_mismatch("wr_ready", wr_ready, !status.full);
            assert (spi_tx_top_i.serializer_i.spi_tx_assertions_i.fail_count == 0) else begin
                $display("a protocol assertion in the serializer failed");
                report_failure();
            end
        end
        sclk_prev = pins.sclk;
    end

    // called on a falling edge, holds the word until the FIFO accepts it
    task automatic write_word(input fifo_pkg::word_t data);
        int cycles;
        cycles   = 0;
        wr_valid = 1'b1;
        wr_data  = data;
        while (!wr_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!wr_ready) begin
            $display("timeout: wr_ready stayed low while a word was offered");
            report_failure();
        end
        expected_q.push_back(data);
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_count < target) begin
            $display("timeout: done did not pulse for frame %0d", target);
            report_failure();
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        wr_valid   = 1'b0;
        wr_data    = '0;
        seed       = 32'h27be;
        rx_word    = '0;
        rx_bits    = 0;
        done_count = 0;
        sclk_prev  = 1'b0;
        saw_full   = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // outputs straight after reset
        assert (done == 1'b0) else show_mismatch("done", done, 1'b0);
        assert (pins == '0) else show_mismatch("pins", pins, 2'b00);
        assert (status.empty) else show_mismatch("status.empty", status.empty, 1'b1);
        assert (!status.full) else show_mismatch("status.full", status.full, 1'b0);
        assert (wr_ready) else show_mismatch("wr_ready", wr_ready, 1'b1);

        // one word, the receiver compares it when done pulses
        write_word(fifo_pkg::word_t'($random(seed)));
        wait_done(1);

        // nothing queued, so the serial side must stay silent
        repeat (200) begin
            @(negedge clk);
            assert (pins == '0) else show_mismatch("pins", pins, 2'b00);
            assert (!done) else show_mismatch("done", done, 1'b0);
        end

        // burst beyond the FIFO depth, back-pressure must kick in
        for (int i = 0; i < `FIFO_DEPTH + 4; i++) begin
            write_word(fifo_pkg::word_t'($random(seed)));
        end
        assert (saw_full) else begin
            $display("the FIFO never reported full during the burst");
            report_failure();
        end

        // each burst word leaves in order with a done pulse of its own
        for (int i = 2; i <= `FIFO_DEPTH + 5; i++) begin
            wait_done(i);
        end

        // after the last word no further frame may start
        repeat (4 * `SPI_DATA_WIDTH + 8) begin
            @(negedge clk);
            assert (!done) else show_mismatch("done", done, 1'b0);
        end
        assert (status.empty) else show_mismatch("status.empty", status.empty, 1'b1);

        if (spi_tx_top_i.serializer_i.spi_tx_assertions_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("a protocol assertion in the serializer failed");
            report_failure();
        end
    end

endmodule

//--- src.f
+incdir+logic
logic/fifo_pkg.sv
logic/spi_pkg.sv
logic/sync_fifo.sv
logic/spi_sclk_gen.sv
logic/spi_serializer.sv
logic/spi_tx_top.sv
verification/spi_tx_assertions.sv
verification/spi_tx_tb.sv

//--- Bender.yml
package:
  name: spi_tx

export_include_dirs:
  - logic

sources:
  - target: any(simulation, synthesis)
    include_dirs:
      - logic
    files:
      - logic/fifo_pkg.sv
      - logic/spi_pkg.sv
      - logic/sync_fifo.sv
      - logic/spi_sclk_gen.sv
      - logic/spi_serializer.sv
      - logic/spi_tx_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/spi_tx_assertions.sv
      - verification/spi_tx_tb.sv
